/* logic/mfp_bus_pkg.sv */
package mfp_bus_pkg;

  // cpu register bus geometry
  localparam int addr_w = 3;
  localparam int data_w = 8;

  // one word per register, address 7 is unused and reads zero
  typedef enum logic [addr_w-1:0] {
    reg_tadr = 3'd0,
    reg_tacr = 3'd1,
    reg_tbdr = 3'd2,
    reg_tbcr = 3'd3,
    reg_ier  = 3'd4,
    // write 1 to clear
    reg_ipr  = 3'd5,
    reg_imr  = 3'd6
  } mfp_reg_e;

  // interrupt sources at the low end of ier, ipr and imr
  localparam int irq_src_n = 4;

  localparam int src_timer_a = 0;
  localparam int src_timer_b = 1;
  // rising edges on the trigger pins
  localparam int src_input_a = 2;
  localparam int src_input_b = 3;

endpackage

/* logic/mfp_timer_pkg.sv */
package mfp_timer_pkg;

  // counting mode, decoded from control bits 3:0
  typedef enum logic [1:0] {
    mode_stopped = 2'd0,
    mode_delay   = 2'd1,
    mode_event   = 2'd2,
    mode_pulse   = 2'd3
  } timer_mode_e;

  // control write is 5 bits, only the low 4 are kept
  localparam int ctrl_w       = 5;
  localparam int mode_w       = 4;
  localparam int ctrl_clr_bit = 4;

  // divide select sits in control bits 2:0
  localparam int div_sel_w = 3;
  localparam int presc_w   = 8;

  // xclk rising edges per prescaler tick
  localparam logic [presc_w-1:0] prescale_div [0:(1 << div_sel_w) - 1] = '{
    8'd2,
    8'd4,
    8'd10,
    8'd16,
    8'd50,
    8'd64,
    8'd100,
    8'd200
  };

endpackage

/* logic/mfp_timer.sv */
`timescale 1ns/1ps

module mfp_timer #(
  parameter int sync_stages = 2
) (
  input  logic                             CLK,
  input  logic                             rst,
  input  logic                             dat_we,
  input  logic                             ctrl_we,
  input  logic [mfp_bus_pkg::data_w-1:0]   wdata,
  input  logic [mfp_timer_pkg::ctrl_w-1:0] ctrl_in,
  input  logic                             xclk,
  input  logic                             t_in,
  output logic [mfp_bus_pkg::data_w-1:0]   counter,
  output logic [mfp_timer_pkg::ctrl_w-1:0] ctrl_rd,
  output logic                             t_out,
  output logic                             expire,
  output logic                             trig_edge,
  output logic                             pulse_mode
);
  import mfp_bus_pkg::*;
  import mfp_timer_pkg::*;

  logic [sync_stages-1:0] xclk_sync;
  logic [sync_stages-1:0] t_sync;
  logic                   xclk_prev;
  logic                   t_prev;
  logic                   xclk_rise;
  logic                   t_level;

  logic [mode_w-1:0]      ctrl_q;
  logic [data_w-1:0]      data_q;
  timer_mode_e            mode;

  logic [presc_w-1:0]     presc_cnt;
  logic [presc_w-1:0]     presc_last;
  logic                   presc_adv;
  logic                   presc_tick;
  logic                   cnt_evt;
  logic                   last_count;

  // both pins are asynchronous to CLK
  always_ff @(posedge CLK) begin
    if (rst) begin
      xclk_sync <= '0;
      t_sync    <= '0;
      xclk_prev <= 1'b0;
      t_prev    <= 1'b0;
    end else begin
      xclk_sync <= {xclk_sync[sync_stages-2:0], xclk};
      t_sync    <= {t_sync[sync_stages-2:0], t_in};
      xclk_prev <= xclk_sync[sync_stages-1];
      t_prev    <= t_sync[sync_stages-1];
    end
  end

  assign t_level   = t_sync[sync_stages-1];
  assign xclk_rise = xclk_sync[sync_stages-1] & ~xclk_prev;
  assign trig_edge = t_level & ~t_prev;

  always_comb begin
    if (ctrl_q == '0) begin
      mode = mode_stopped;
    end else if (!ctrl_q[3]) begin
      mode = mode_delay;
    end else if (ctrl_q[2:0] == '0) begin
      mode = mode_event;
    end else begin
      mode = mode_pulse;
    end
  end

  // in pulse mode xclk only counts while the trigger is high
  assign presc_last = prescale_div[ctrl_q[div_sel_w-1:0]] - 1'b1;
  assign presc_adv  = xclk_rise && ((mode == mode_delay) || ((mode == mode_pulse) && t_level));
  assign presc_tick = presc_adv && (presc_cnt >= presc_last);

  always_ff @(posedge CLK) begin
    if (rst || ctrl_we) begin
      presc_cnt <= '0;
    end else if (presc_adv) begin
      if (presc_cnt >= presc_last) begin
        presc_cnt <= '0;
      end else begin
        presc_cnt <= presc_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    case (mode)
      mode_delay: cnt_evt = presc_tick;
      mode_event: cnt_evt = trig_edge;
      mode_pulse: cnt_evt = presc_tick;
      default:    cnt_evt = 1'b0;
    endcase
  end

  assign last_count = cnt_evt && (counter == data_w'(1));

  always_ff @(posedge CLK) begin
    if (rst) begin
      ctrl_q  <= '0;
      data_q  <= '0;
      counter <= '0;
      t_out   <= 1'b0;
      expire  <= 1'b0;
    end else begin
      expire <= last_count;
      if (cnt_evt) begin
        // time-out reloads and toggles the output level
        if (last_count) begin
          counter <= data_q;
          t_out   <= ~t_out;
        end else begin
          counter <= counter - 1'b1;
        end
      end
      // a cpu write overrides the count
      if (dat_we) begin
        data_q  <= wdata;
        counter <= wdata;
      end
      if (ctrl_we) begin
        ctrl_q <= ctrl_in[mode_w-1:0];
        if (ctrl_in[ctrl_clr_bit]) begin
          t_out <= 1'b0;
        end
      end
    end
  end

  assign ctrl_rd    = {t_out, ctrl_q};
  assign pulse_mode = (mode == mode_pulse);

  // strobe follows the counting edge, mode seen there must be running
  a_no_expire_stopped: assert property (
    @(posedge CLK) disable iff (rst) expire |-> ($past(mode) != mode_stopped)
  );

  // counter stays in 1..data once a nonzero value is loaded
  a_counter_nonzero: assert property (
    @(posedge CLK) disable iff (rst) (data_q != '0) |-> (counter != '0)
  );

endmodule

/* logic/mfp_bus_regs.sv */
`timescale 1ns/1ps

module mfp_bus_regs (
  input  logic                             CLK,
  input  logic                             rst,
  input  logic                             sel,
  input  logic                             we,
  input  mfp_bus_pkg::mfp_reg_e            addr,
  input  logic [mfp_bus_pkg::data_w-1:0]   wdata,
  input  logic [mfp_bus_pkg::data_w-1:0]   counter_a,
  input  logic [mfp_bus_pkg::data_w-1:0]   counter_b,
  input  logic [mfp_timer_pkg::ctrl_w-1:0] ctrl_rd_a,
  input  logic [mfp_timer_pkg::ctrl_w-1:0] ctrl_rd_b,
  input  logic [mfp_bus_pkg::data_w-1:0]   ier,
  input  logic [mfp_bus_pkg::data_w-1:0]   ipr,
  input  logic [mfp_bus_pkg::data_w-1:0]   imr,
  output logic [mfp_bus_pkg::data_w-1:0]   rdata,
  output logic                             dat_we_a,
  output logic                             ctrl_we_a,
  output logic                             dat_we_b,
  output logic                             ctrl_we_b,
  output logic                             ier_we,
  output logic                             ipr_clr_we,
  output logic                             imr_we
);
  import mfp_bus_pkg::*;

  logic              wr;
  logic [data_w-1:0] rd_mux;

  assign wr = sel && we;

  // one strobe per write, decoded straight from the address
  always_comb begin
    dat_we_a   = 1'b0;
    ctrl_we_a  = 1'b0;
    dat_we_b   = 1'b0;
    ctrl_we_b  = 1'b0;
    ier_we     = 1'b0;
    ipr_clr_we = 1'b0;
    imr_we     = 1'b0;
    if (wr) begin
      case (addr)
        reg_tadr: dat_we_a   = 1'b1;
        reg_tacr: ctrl_we_a  = 1'b1;
        reg_tbdr: dat_we_b   = 1'b1;
        reg_tbcr: ctrl_we_b  = 1'b1;
        reg_ier:  ier_we     = 1'b1;
        reg_ipr:  ipr_clr_we = 1'b1;
        reg_imr:  imr_we     = 1'b1;
        default:  ;
      endcase
    end
  end

  // data registers read back as the live counters
  always_comb begin
    case (addr)
      reg_tadr: rd_mux = counter_a;
      reg_tacr: rd_mux = data_w'(ctrl_rd_a);
      reg_tbdr: rd_mux = counter_b;
      reg_tbcr: rd_mux = data_w'(ctrl_rd_b);
      reg_ier:  rd_mux = ier;
      reg_ipr:  rd_mux = ipr;
      reg_imr:  rd_mux = imr;
      default:  rd_mux = '0;
    endcase
  end

  assign rdata = sel ? rd_mux : '0;

  a_one_strobe: assert property (
    @(posedge CLK) disable iff (rst)
      $onehot0({dat_we_a, ctrl_we_a, dat_we_b, ctrl_we_b, ier_we, ipr_clr_we, imr_we})
  );

endmodule

/* logic/mfp_irq_ctrl.sv */
`timescale 1ns/1ps

module mfp_irq_ctrl (
  input  logic                           CLK,
  input  logic                           rst,
  input  logic [mfp_bus_pkg::data_w-1:0] wdata,
  input  logic                           ier_we,
  input  logic                           ipr_clr_we,
  input  logic                           imr_we,
  input  logic                           expire_a,
  input  logic                           expire_b,
  input  logic                           trig_edge_a,
  input  logic                           trig_edge_b,
  input  logic                           pulse_mode_a,
  input  logic                           pulse_mode_b,
  output logic [mfp_bus_pkg::data_w-1:0] ier,
  output logic [mfp_bus_pkg::data_w-1:0] ipr,
  output logic [mfp_bus_pkg::data_w-1:0] imr,
  output logic                           irq
);
  import mfp_bus_pkg::*;

  logic [irq_src_n-1:0] ier_q;
  logic [irq_src_n-1:0] ipr_q;
  logic [irq_src_n-1:0] imr_q;
  logic [irq_src_n-1:0] src;
  logic [irq_src_n-1:0] clr;

  // input pins are not interrupt sources while their timer gates on them
  assign src[src_timer_a] = expire_a;
  assign src[src_timer_b] = expire_b;
  assign src[src_input_a] = trig_edge_a & ~pulse_mode_a;
  assign src[src_input_b] = trig_edge_b & ~pulse_mode_b;

  assign clr = ipr_clr_we ? wdata[irq_src_n-1:0] : '0;

  always_ff @(posedge CLK) begin
    if (rst) begin
      ier_q <= '0;
      ipr_q <= '0;
      imr_q <= '0;
      irq   <= 1'b0;
    end else begin
      if (ier_we) begin
        ier_q <= wdata[irq_src_n-1:0];
      end
      if (imr_we) begin
        imr_q <= wdata[irq_src_n-1:0];
      end
      // a new event beats a clear in the same cycle
      ipr_q <= (ipr_q & ~clr) | (src & ier_q);
      irq   <= |(ipr_q & imr_q);
    end
  end

  // upper bits have no source behind them
  assign ier = data_w'(ier_q);
  assign ipr = data_w'(ipr_q);
  assign imr = data_w'(imr_q);

endmodule

/* logic/mfp_timers_top.sv */
`timescale 1ns/1ps

module mfp_timers_top #(
  parameter int sync_stages = 2
) (
  input  logic                           CLK,
  input  logic                           rst,
  input  logic                           sel,
  input  logic                           we,
  input  mfp_bus_pkg::mfp_reg_e          addr,
  input  logic [mfp_bus_pkg::data_w-1:0] wdata,
  output logic [mfp_bus_pkg::data_w-1:0] rdata,
  input  logic                           xclk_a,
  input  logic                           t_in_a,
  output logic                           t_out_a,
  input  logic                           xclk_b,
  input  logic                           t_in_b,
  output logic                           t_out_b,
  output logic                           irq
);
  import mfp_bus_pkg::*;
  import mfp_timer_pkg::*;

  logic [data_w-1:0] counter_a;
  logic [data_w-1:0] counter_b;
  logic [ctrl_w-1:0] ctrl_rd_a;
  logic [ctrl_w-1:0] ctrl_rd_b;
  logic [data_w-1:0] ier;
  logic [data_w-1:0] ipr;
  logic [data_w-1:0] imr;
  logic              dat_we_a;
  logic              ctrl_we_a;
  logic              dat_we_b;
  logic              ctrl_we_b;
  logic              ier_we;
  logic              ipr_clr_we;
  logic              imr_we;
  logic              expire_a;
  logic              expire_b;
  logic              trig_edge_a;
  logic              trig_edge_b;
  logic              pulse_mode_a;
  logic              pulse_mode_b;

  mfp_bus_regs u_bus_regs (
    .CLK        (CLK),
    .rst        (rst),
    .sel        (sel),
    .we         (we),
    .addr       (addr),
    .wdata      (wdata),
    .counter_a  (counter_a),
    .counter_b  (counter_b),
    .ctrl_rd_a  (ctrl_rd_a),
    .ctrl_rd_b  (ctrl_rd_b),
    .ier        (ier),
    .ipr        (ipr),
    .imr        (imr),
    .rdata      (rdata),
    .dat_we_a   (dat_we_a),
    .ctrl_we_a  (ctrl_we_a),
    .dat_we_b   (dat_we_b),
    .ctrl_we_b  (ctrl_we_b),
    .ier_we     (ier_we),
    .ipr_clr_we (ipr_clr_we),
    .imr_we     (imr_we)
  );

  // control write takes the low bits of the bus word
  mfp_timer #(
    .sync_stages (sync_stages)
  ) timer_a (
    .CLK        (CLK),
    .rst        (rst),
    .dat_we     (dat_we_a),
    .ctrl_we    (ctrl_we_a),
    .wdata      (wdata),
    .ctrl_in    (wdata[ctrl_w-1:0]),
    .xclk       (xclk_a),
    .t_in       (t_in_a),
    .counter    (counter_a),
    .ctrl_rd    (ctrl_rd_a),
    .t_out      (t_out_a),
    .expire     (expire_a),
    .trig_edge  (trig_edge_a),
    .pulse_mode (pulse_mode_a)
  );

  mfp_timer #(
    .sync_stages (sync_stages)
  ) timer_b (
    .CLK        (CLK),
    .rst        (rst),
    .dat_we     (dat_we_b),
    .ctrl_we    (ctrl_we_b),
    .wdata      (wdata),
    .ctrl_in    (wdata[ctrl_w-1:0]),
    .xclk       (xclk_b),
    .t_in       (t_in_b),
    .counter    (counter_b),
    .ctrl_rd    (ctrl_rd_b),
    .t_out      (t_out_b),
    .expire     (expire_b),
    .trig_edge  (trig_edge_b),
    .pulse_mode (pulse_mode_b)
  );

  mfp_irq_ctrl u_irq_ctrl (
    .CLK          (CLK),
    .rst          (rst),
    .wdata        (wdata),
    .ier_we       (ier_we),
    .ipr_clr_we   (ipr_clr_we),
    .imr_we       (imr_we),
    .expire_a     (expire_a),
    .expire_b     (expire_b),
    .trig_edge_a  (trig_edge_a),
    .trig_edge_b  (trig_edge_b),
    .pulse_mode_a (pulse_mode_a),
    .pulse_mode_b (pulse_mode_b),
    .ier          (ier),
    .ipr          (ipr),
    .imr          (imr),
    .irq          (irq)
  );

endmodule

/* verif/mfp_timers_tb.sv */
`timescale 1ns/1ps

module mfp_timers_tb;
  import mfp_bus_pkg::*;

  // all tests together stay well under 200 pin edges of 16 cycles each
  localparam int max_cycles = 20000;
  localparam int pin_xclk_a = 0;
  localparam int pin_xclk_b = 1;
  localparam int pin_t_in_a = 2;
  localparam int pin_t_in_b = 3;

  logic        CLK;
  logic        rst;
  logic        sel;
  logic        we;
  mfp_reg_e    addr;
  logic [7:0]  wdata;
  logic [7:0]  rdata;
  logic        xclk_a;
  logic        t_in_a;
  logic        t_out_a;
  logic        xclk_b;
  logic        t_in_b;
  logic        t_out_b;
  logic        irq;

  integer      seed = 38;
  int          cycle_cnt = 0;

  mfp_timers_top #(
    .sync_stages (2)
  ) dut (
    .CLK     (CLK),
    .rst     (rst),
    .sel     (sel),
    .we      (we),
    .addr    (addr),
    .wdata   (wdata),
    .rdata   (rdata),
    .xclk_a  (xclk_a),
    .t_in_a  (t_in_a),
    .t_out_a (t_out_a),
    .xclk_b  (xclk_b),
    .t_in_b  (t_in_b),
    .t_out_b (t_out_b),
    .irq     (irq)
  );

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      $display("timeout: the tests did not finish within %0d cycles", max_cycles);
      $display("Simulation failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  function automatic int rand_below(input int n);
    return {$random(seed)} % n;
  endfunction

  // data values stay in 3..9
  function automatic logic [7:0] rand_data();
    return 8'(3 + rand_below(7));
  endfunction

  // counter after n events where 0 wraps to the reload value
  function automatic logic [7:0] expected_count(input int d, input int n);
    return 8'(d - (n % d));
  endfunction

  task automatic check(input string name, input logic [7:0] expected,
                       input logic [7:0] actual);
    if (expected !== actual) begin
      $display("error: %s expected %0h actual %0h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic hold_cycles(input int n);
    repeat (n) @(posedge CLK);
    #1;
  endtask

  task automatic write_reg(input mfp_reg_e a, input logic [7:0] d);
    sel   = 1'b1;
    we    = 1'b1;
    addr  = a;
    wdata = d;
    @(posedge CLK);
    #1;
    sel = 1'b0;
    we  = 1'b0;
  endtask

  task automatic read_reg(input mfp_reg_e a, output logic [7:0] d);
    sel  = 1'b1;
    we   = 1'b0;
    addr = a;
    #2;
    d = rdata;
    @(posedge CLK);
    #1;
    sel = 1'b0;
  endtask

  task automatic set_pin(input int pin, input logic level);
    case (pin)
      pin_xclk_a: xclk_a = level;
      pin_xclk_b: xclk_b = level;
      pin_t_in_a: t_in_a = level;
      default:    t_in_b = level;
    endcase
  endtask

  // one rising edge with each level held 8 cycles for the synchronizers
  task automatic pulse_pin(input int pin);
    set_pin(pin, 1'b1);
    hold_cycles(8);
    set_pin(pin, 1'b0);
    hold_cycles(8);
  endtask

  task automatic reset_readback();
    logic [7:0] rd;
    logic [7:0] d;
    for (int i = 0; i < 8; i++) begin
      read_reg(mfp_reg_e'(i), rd);
      check("reset readback", 8'h00, rd);
    end
    check("reset irq", 8'h00, {7'b0, irq});
    check("reset t_out_a", 8'h00, {7'b0, t_out_a});
    check("reset t_out_b", 8'h00, {7'b0, t_out_b});
    d = rand_data();
    write_reg(reg_tadr, d);
    read_reg(reg_tadr, rd);
    check("data readback a", d, rd);
    // bit 4 is a command and does not read back
    write_reg(reg_tacr, 8'h1a);
    read_reg(reg_tacr, rd);
    check("control readback a", 8'h0a, rd);
    write_reg(reg_tacr, 8'h00);
    d = rand_data();
    write_reg(reg_tbdr, d);
    read_reg(reg_tbdr, rd);
    check("data readback b", d, rd);
    write_reg(reg_tbcr, 8'h05);
    read_reg(reg_tbcr, rd);
    check("control readback b", 8'h05, rd);
    write_reg(reg_tbcr, 8'h00);
  endtask

  task automatic delay_mode_a();
    logic [7:0] rd;
    int d;
    int e;
    int ticks;
    int outs;
    d     = int'(rand_data());
    e     = 4 * (d + 1 + rand_below(d + 1)) + rand_below(4);
    ticks = e / 4;
    outs  = ticks / d;
    write_reg(reg_ipr, 8'h0f);
    write_reg(reg_ier, 8'h01);
    write_reg(reg_imr, 8'h01);
    write_reg(reg_tadr, 8'(d));
    // delay mode, divide by 4, output cleared
    write_reg(reg_tacr, 8'h11);
    repeat (e) pulse_pin(pin_xclk_a);
    write_reg(reg_tacr, 8'h00);
    read_reg(reg_tadr, rd);
    check("delay mode counter", expected_count(d, ticks), rd);
    check("delay mode t_out_a", 8'(outs % 2), {7'b0, t_out_a});
    read_reg(reg_tacr, rd);
    check("delay mode control", 8'((outs % 2) << 4), rd);
    read_reg(reg_ipr, rd);
    check("delay mode pending", (outs > 0) ? 8'h01 : 8'h00, rd);
    check("delay mode irq", (outs > 0) ? 8'h01 : 8'h00, {7'b0, irq});
  endtask

  task automatic event_mode_b();
    logic [7:0] rd;
    int d;
    int n;
    int outs;
    d    = int'(rand_data());
    n    = 1 + rand_below(2 * d + 2);
    outs = n / d;
    write_reg(reg_ipr, 8'h0f);
    write_reg(reg_ier, 8'h0a);
    write_reg(reg_imr, 8'h00);
    write_reg(reg_tbdr, 8'(d));
    write_reg(reg_tbcr, 8'h18);
    repeat (n) pulse_pin(pin_t_in_b);
    write_reg(reg_tbcr, 8'h00);
    read_reg(reg_tbdr, rd);
    check("event mode counter", expected_count(d, n), rd);
    check("event mode t_out_b", 8'(outs % 2), {7'b0, t_out_b});
    read_reg(reg_ipr, rd);
    check("event mode pending", (outs > 0) ? 8'h0a : 8'h08, rd);
  endtask

  task automatic pulse_mode_a();
    logic [7:0] rd;
    int d;
    int p;
    int ticks;
    d     = int'(rand_data());
    p     = 8 + rand_below(24);
    ticks = p / 4;
    write_reg(reg_ipr, 8'h0f);
    write_reg(reg_ier, 8'h04);
    write_reg(reg_imr, 8'h00);
    write_reg(reg_tadr, 8'(d));
    write_reg(reg_tacr, 8'h19);
    // gate low so these edges are ignored
    repeat (8) pulse_pin(pin_xclk_a);
    read_reg(reg_tadr, rd);
    check("pulse mode gated counter", 8'(d), rd);
    set_pin(pin_t_in_a, 1'b1);
    hold_cycles(8);
    repeat (p) pulse_pin(pin_xclk_a);
    set_pin(pin_t_in_a, 1'b0);
    hold_cycles(8);
    read_reg(reg_tadr, rd);
    check("pulse mode counter", expected_count(d, ticks), rd);
    check("pulse mode t_out_a", 8'((ticks / d) % 2), {7'b0, t_out_a});
    read_reg(reg_ipr, rd);
    check("pulse mode input blocked", 8'h00, rd);
    // same pin is an interrupt source again in delay mode
    write_reg(reg_tacr, 8'h01);
    pulse_pin(pin_t_in_a);
    read_reg(reg_ipr, rd);
    check("delay mode input pending", 8'h04, rd);
  endtask

  task automatic clear_and_mask();
    logic [7:0] rd;
    write_reg(reg_ipr, 8'h0f);
    write_reg(reg_ier, 8'h0c);
    write_reg(reg_imr, 8'h04);
    pulse_pin(pin_t_in_b);
    read_reg(reg_ipr, rd);
    check("masked pending", 8'h08, rd);
    check("masked irq", 8'h00, {7'b0, irq});
    pulse_pin(pin_t_in_a);
    read_reg(reg_ipr, rd);
    check("unmasked pending", 8'h0c, rd);
    check("unmasked irq", 8'h01, {7'b0, irq});
    write_reg(reg_ipr, 8'h04);
    hold_cycles(2);
    read_reg(reg_ipr, rd);
    check("partial clear pending", 8'h08, rd);
    check("partial clear irq", 8'h00, {7'b0, irq});
    write_reg(reg_ipr, 8'h08);
    read_reg(reg_ipr, rd);
    check("full clear pending", 8'h00, rd);
    // reload of 1 makes every edge a time-out
    write_reg(reg_tbdr, 8'h01);
    write_reg(reg_tbcr, 8'h18);
    pulse_pin(pin_t_in_b);
    read_reg(reg_tbcr, rd);
    check("t_out_b set readback", 8'h18, rd);
    check("t_out_b set pin", 8'h01, {7'b0, t_out_b});
    write_reg(reg_tbcr, 8'h18);
    read_reg(reg_tbcr, rd);
    check("t_out_b clear readback", 8'h08, rd);
    check("t_out_b clear pin", 8'h00, {7'b0, t_out_b});
  endtask

  initial begin
    rst    = 1'b1;
    sel    = 1'b0;
    we     = 1'b0;
    addr   = reg_tadr;
    wdata  = 8'h00;
    xclk_a = 1'b0;
    t_in_a = 1'b0;
    xclk_b = 1'b0;
    t_in_b = 1'b0;
    repeat (2) @(posedge CLK);
    #1;
    rst = 1'b0;
    hold_cycles(2);
    reset_readback();
    delay_mode_a();
    event_mode_b();
    pulse_mode_a();
    clear_and_mask();
    $display("Simulation passed");
    $finish;
  end

endmodule

/* filelist.f */
logic/mfp_bus_pkg.sv
logic/mfp_timer_pkg.sv
logic/mfp_timer.sv
logic/mfp_bus_regs.sv
logic/mfp_irq_ctrl.sv
logic/mfp_timers_top.sv
verif/mfp_timers_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := mfp_timers_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
